// ==== filelist.f ====
common/csr_pkg.sv
common/trap_pkg.sv
csr/csr_write_stage.sv
csr/csr_reg_bank.sv
csr/csr_read_port.sv
csr/csr_unit.sv
testbench/csr_unit_assertions.sv
testbench/csr_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := csr_unit_tb
FILELIST  := filelist.f
OBJDIR    := obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== testbench/csr_unit_tb.sv ====
`timescale 1ns/1ps

module csr_unit_tb;

  localparam int COMMIT_WIDTH = 4;

  logic                          clk = 1'b0;
  logic                          reset;
  logic                          flush_i;
  logic                          wr_en_i;
  csr_pkg::csr_wr_req_t          wr_req_i;
  logic                          commit_i;
  logic                          rd_en_i;
  csr_pkg::csr_addr_t            rd_addr_i;
  csr_pkg::csr_data_t            rd_data_o;
  logic                          atomic_vio_o;
  logic [$clog2(COMMIT_WIDTH):0] retired_i;
  trap_pkg::exc_report_t         exc_i;
  logic                          sret_i;
  csr_pkg::csr_data_t            fflags_i;
  csr_pkg::csr_data_t            epc_o;
  csr_pkg::csr_data_t            evec_o;
  csr_pkg::csr_data_t            status_o;
  csr_pkg::csr_data_t            frm_o;

  // reference model state
  csr_pkg::csr_set_t    model_csrs;
  csr_pkg::csr_wr_req_t model_stage;
  logic                 model_pending;
  csr_pkg::csr_addr_t   model_ck_addr;
  csr_pkg::csr_data_t   model_ck_data;
  logic                 model_ck_valid;

  int                   seed;
  csr_pkg::csr_addr_t   kept_addr[$];
  csr_pkg::csr_addr_t   counter_addr[$];
  trap_pkg::cause_t     causes[$];

  always #4 clk = ~clk;

  csr_unit #(
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) u_dut (
    .clk          (clk),
    .reset        (reset),
    .flush_i      (flush_i),
    .wr_en_i      (wr_en_i),
    .wr_req_i     (wr_req_i),
    .commit_i     (commit_i),
    .rd_en_i      (rd_en_i),
    .rd_addr_i    (rd_addr_i),
    .rd_data_o    (rd_data_o),
    .atomic_vio_o (atomic_vio_o),
    .retired_i    (retired_i),
    .exc_i        (exc_i),
    .sret_i       (sret_i),
    .fflags_i     (fflags_i),
    .epc_o        (epc_o),
    .evec_o       (evec_o),
    .status_o     (status_o),
    .frm_o        (frm_o)
  );

  // expected value at an address or zero when unmapped
  function automatic csr_pkg::csr_data_t model_read(input csr_pkg::csr_addr_t addr);
    csr_pkg::csr_data_t val;
    case (addr)
      csr_pkg::ADDR_FFLAGS:   val = model_csrs.fflags;
      csr_pkg::ADDR_FRM:      val = model_csrs.frm;
      csr_pkg::ADDR_FCSR:     val = model_csrs.fcsr;
      csr_pkg::ADDR_SUP0:     val = model_csrs.sup0;
      csr_pkg::ADDR_SUP1:     val = model_csrs.sup1;
      csr_pkg::ADDR_EPC:      val = model_csrs.epc;
      csr_pkg::ADDR_BADVADDR: val = model_csrs.badvaddr;
      csr_pkg::ADDR_COUNT:    val = model_csrs.count;
      csr_pkg::ADDR_EVEC:     val = model_csrs.evec;
      csr_pkg::ADDR_CAUSE:    val = model_csrs.cause;
      csr_pkg::ADDR_STATUS:   val = model_csrs.status;
      csr_pkg::ADDR_CYCLE:    val = model_csrs.cycle;
      csr_pkg::ADDR_TIME:     val = model_csrs.time_csr;
      csr_pkg::ADDR_INSTRET:  val = model_csrs.instret;
      default:                val = '0;
    endcase
    return val;
  endfunction

  // bits that survive a software write
  function automatic csr_pkg::csr_data_t write_mask(input csr_pkg::csr_addr_t addr);
    if (addr == csr_pkg::ADDR_FFLAGS || addr == csr_pkg::ADDR_FRM)
      return csr_pkg::LOW_WORD_MASK;
    else if (addr == csr_pkg::ADDR_STATUS)
      return csr_pkg::STATUS_WRITE_MASK;
    else
      return '1;
  endfunction

  // advance the model by one edge using the inputs sampled there
  task automatic model_step();
    csr_pkg::csr_set_t  nxt;
    csr_pkg::csr_data_t wdata;
    nxt = model_csrs;
    nxt.fflags = model_csrs.fflags | (fflags_i & csr_pkg::LOW_WORD_MASK);
    nxt.fcsr   = model_csrs.fcsr | (fflags_i & csr_pkg::LOW_WORD_MASK);
    // excepting instruction counts as retired too
    nxt.count = model_csrs.count + csr_pkg::csr_data_t'(retired_i)
              + csr_pkg::csr_data_t'(exc_i.valid);
    nxt.cycle    = nxt.count;
    nxt.time_csr = nxt.count;
    nxt.instret  = nxt.count;
    if (exc_i.valid)
    begin
      nxt.epc   = exc_i.pc;
      nxt.cause = csr_pkg::csr_data_t'(exc_i.cause);
      if (exc_i.cause == trap_pkg::CAUSE_MISALIGNED_FETCH ||
          exc_i.cause == trap_pkg::CAUSE_FAULT_FETCH)
        nxt.badvaddr = exc_i.pc;
      else if (exc_i.cause == trap_pkg::CAUSE_MISALIGNED_LOAD ||
               exc_i.cause == trap_pkg::CAUSE_FAULT_LOAD)
        nxt.badvaddr = exc_i.ld_addr;
      else if (exc_i.cause == trap_pkg::CAUSE_MISALIGNED_STORE ||
               exc_i.cause == trap_pkg::CAUSE_FAULT_STORE)
        nxt.badvaddr = exc_i.st_addr;
    end
    if (sret_i)
    begin
      nxt.status[csr_pkg::SR_S]  = model_csrs.status[csr_pkg::SR_PS];
      nxt.status[csr_pkg::SR_EI] = model_csrs.status[csr_pkg::SR_PEI];
    end
    // software write beats every autonomous update
    if (commit_i && model_pending)
    begin
      wdata = model_stage.data & write_mask(model_stage.addr);
      case (model_stage.addr)
        csr_pkg::ADDR_FFLAGS:   nxt.fflags   = wdata;
        csr_pkg::ADDR_FRM:      nxt.frm      = wdata;
        csr_pkg::ADDR_FCSR:     nxt.fcsr     = wdata;
        csr_pkg::ADDR_SUP0:     nxt.sup0     = wdata;
        csr_pkg::ADDR_SUP1:     nxt.sup1     = wdata;
        csr_pkg::ADDR_EPC:      nxt.epc      = wdata;
        csr_pkg::ADDR_BADVADDR: nxt.badvaddr = wdata;
        csr_pkg::ADDR_COUNT:    nxt.count    = wdata;
        csr_pkg::ADDR_EVEC:     nxt.evec     = wdata;
        csr_pkg::ADDR_CAUSE:    nxt.cause    = wdata;
        csr_pkg::ADDR_STATUS:   nxt.status   = wdata;
        csr_pkg::ADDR_CYCLE:    nxt.cycle    = wdata;
        csr_pkg::ADDR_TIME:     nxt.time_csr = wdata;
        csr_pkg::ADDR_INSTRET:  nxt.instret  = wdata;
        default:                ;
      endcase
    end
    // checkpoint holds the value seen before this edge
    if (rd_en_i)
    begin
      model_ck_addr  = rd_addr_i;
      model_ck_data  = model_read(rd_addr_i);
      model_ck_valid = 1'b1;
    end
    else if (flush_i || commit_i)
      model_ck_valid = 1'b0;
    if (wr_en_i)
    begin
      model_stage   = wr_req_i;
      model_pending = 1'b1;
    end
    else if (flush_i)
      model_pending = 1'b0;
    model_csrs = nxt;
  endtask

  task automatic compare_data(input string name, input csr_pkg::csr_data_t exp,
                              input csr_pkg::csr_data_t act);
    if (act !== exp)
    begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  // one rising edge with the pulses falling back to idle
  task automatic next_cycle();
    @(posedge clk);
    model_step();
    wr_en_i     <= 1'b0;
    commit_i    <= 1'b0;
    flush_i     <= 1'b0;
    rd_en_i     <= 1'b0;
    sret_i      <= 1'b0;
    exc_i.valid <= 1'b0;
    retired_i   <= '0;
    fflags_i    <= '0;
  endtask

  // outputs are compared mid-cycle where they are settled
  task automatic check_all(input string name);
    @(negedge clk);
    compare_data({name, " rd_data_o"}, model_read(rd_addr_i), rd_data_o);
    compare_data({name, " epc_o"}, model_csrs.epc, epc_o);
    compare_data({name, " evec_o"}, model_csrs.evec, evec_o);
    compare_data({name, " status_o"}, model_csrs.status, status_o);
    compare_data({name, " frm_o"}, model_csrs.frm, frm_o);
    compare_flag({name, " atomic_vio_o"},
                 model_ck_valid && (model_read(model_ck_addr) != model_ck_data),
                 atomic_vio_o);
  endtask

  // stage and commit a write and then flush away the still-pending entry
  task automatic stage_commit(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_data_t data,
                              input string name);
    next_cycle();
    wr_en_i   <= 1'b1;
    wr_req_i  <= '{addr: addr, data: data};
    rd_addr_i <= addr;
    check_all(name);
    next_cycle();
    commit_i <= 1'b1;
    check_all(name);
    next_cycle();
    flush_i <= 1'b1;
    check_all(name);
    compare_data({name, " committed value"}, data & write_mask(addr), rd_data_o);
  endtask

  task automatic wait_flag(input logic exp, input int limit, input string name);
    int n;
    n = 0;
    while (atomic_vio_o !== exp && n < limit)
    begin
      next_cycle();
      check_all(name);
      n++;
    end
    if (atomic_vio_o !== exp)
    begin
      $display("%s: atomic_vio_o did not reach %b within %0d cycles", name, exp, limit);
      $display("Simulation finished: FAIL");
      $fatal(1, "timeout");
    end
  endtask

  initial
  begin
    int                 idx;
    csr_pkg::csr_addr_t addr;
    csr_pkg::csr_data_t old;
    seed = 32'h748a;
    kept_addr = '{csr_pkg::ADDR_FFLAGS, csr_pkg::ADDR_FRM, csr_pkg::ADDR_FCSR,
                  csr_pkg::ADDR_SUP0, csr_pkg::ADDR_SUP1, csr_pkg::ADDR_EPC,
                  csr_pkg::ADDR_BADVADDR, csr_pkg::ADDR_COUNT, csr_pkg::ADDR_EVEC,
                  csr_pkg::ADDR_CAUSE, csr_pkg::ADDR_STATUS, csr_pkg::ADDR_CYCLE,
                  csr_pkg::ADDR_TIME, csr_pkg::ADDR_INSTRET};
    counter_addr = '{csr_pkg::ADDR_COUNT, csr_pkg::ADDR_CYCLE, csr_pkg::ADDR_TIME,
                     csr_pkg::ADDR_INSTRET};
    // 2, 3 and 9 carry no faulting address
    causes = '{4'd0, 4'd1, 4'd4, 4'd5, 4'd6, 4'd7, 4'd2, 4'd3, 4'd9};
    reset     <= 1'b1;
    flush_i   <= 1'b0;
    wr_en_i   <= 1'b0;
    wr_req_i  <= '0;
    commit_i  <= 1'b0;
    rd_en_i   <= 1'b0;
    rd_addr_i <= '0;
    retired_i <= '0;
    exc_i     <= '0;
    sret_i    <= 1'b0;
    fflags_i  <= '0;
    model_csrs        = '0;
    model_csrs.status = csr_pkg::STATUS_RESET;
    model_pending     = 1'b0;
    model_ck_valid    = 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    check_all("reset");

    // staged write lands one cycle after commit
    for (int i = 0; i < 10; i++)
    begin
      idx = $unsigned($random(seed)) % 14;
      stage_commit(kept_addr[idx], {$random(seed), $random(seed)}, "staged write");
    end
    // flushed write must not land
    for (int i = 0; i < 4; i++)
    begin
      idx  = $unsigned($random(seed)) % 14;
      addr = kept_addr[idx];
      next_cycle();
      rd_addr_i <= addr;
      check_all("flush setup");
      old = model_read(addr);
      next_cycle();
      wr_en_i  <= 1'b1;
      wr_req_i <= '{addr: addr, data: ~old};
      check_all("flush stage");
      next_cycle();
      flush_i <= 1'b1;
      check_all("flush");
      next_cycle();
      commit_i <= 1'b1;
      check_all("flush commit");
      next_cycle();
      check_all("flushed write");
      compare_data("flushed write value", old, rd_data_o);
    end

    // trap capture with badvaddr picked by cause
    for (int i = 0; i < 12; i++)
    begin
      idx = $unsigned($random(seed)) % 9;
      next_cycle();
      exc_i     <= '{valid: 1'b1, pc: {$random(seed), $random(seed)}, cause: causes[idx],
                     ld_addr: {$random(seed), $random(seed)},
                     st_addr: {$random(seed), $random(seed)}};
      rd_addr_i <= csr_pkg::ADDR_BADVADDR;
      check_all("exception");
      next_cycle();
      rd_addr_i <= csr_pkg::ADDR_CAUSE;
      check_all("exception cause");
      next_cycle();
      rd_addr_i <= csr_pkg::ADDR_BADVADDR;
      check_all("exception badvaddr");
    end

    // counters follow retired counts plus exceptions
    for (int i = 0; i < 24; i++)
    begin
      next_cycle();
      retired_i   <= 3'($unsigned($random(seed)) % 5);
      exc_i.valid <= 1'($random(seed));
      rd_addr_i   <= counter_addr[i % 4];
      check_all("counter");
    end

    // FP flags accumulate until a write overrides them
    for (int i = 0; i < 10; i++)
    begin
      next_cycle();
      fflags_i  <= {$random(seed), $random(seed)};
      rd_addr_i <= (i % 2 == 0) ? csr_pkg::ADDR_FFLAGS : csr_pkg::ADDR_FCSR;
      check_all("fflags accumulate");
    end
    stage_commit(csr_pkg::ADDR_FFLAGS, {$random(seed), $random(seed)}, "fflags write");
    stage_commit(csr_pkg::ADDR_FCSR, {$random(seed), $random(seed)}, "fcsr write");

    // sret pops PS into S and PEI into EI
    for (int i = 0; i < 6; i++)
    begin
      stage_commit(csr_pkg::ADDR_STATUS, {$random(seed), $random(seed)}, "status write");
      next_cycle();
      sret_i <= 1'b1;
      check_all("sret");
      next_cycle();
      check_all("sret result");
    end

    // epc changed under a live checkpoint
    next_cycle();
    rd_en_i   <= 1'b1;
    rd_addr_i <= csr_pkg::ADDR_EPC;
    check_all("read epc");
    next_cycle();
    exc_i <= '{valid: 1'b1, pc: model_csrs.epc + 64'h40, cause: 4'd2, ld_addr: '0,
               st_addr: '0};
    check_all("epc change");
    wait_flag(1'b1, 4, "epc violation rise");
    next_cycle();
    commit_i <= 1'b1;
    check_all("epc commit");
    wait_flag(1'b0, 4, "epc violation clear");
    // count changed under a live checkpoint
    next_cycle();
    rd_en_i   <= 1'b1;
    rd_addr_i <= csr_pkg::ADDR_COUNT;
    check_all("read count");
    next_cycle();
    retired_i <= 3'(1 + $unsigned($random(seed)) % 4);
    check_all("count change");
    wait_flag(1'b1, 4, "count violation rise");
    next_cycle();
    commit_i <= 1'b1;
    check_all("count commit");
    wait_flag(1'b0, 4, "count violation clear");
    // scratch register is untouched by commit-stage events
    next_cycle();
    rd_en_i   <= 1'b1;
    rd_addr_i <= csr_pkg::ADDR_SUP0;
    check_all("read sup0");
    for (int i = 0; i < 8; i++)
    begin
      next_cycle();
      retired_i   <= 3'($unsigned($random(seed)) % 5);
      exc_i.valid <= 1'($random(seed));
      fflags_i    <= {$random(seed), $random(seed)};
      check_all("stable read");
      compare_flag("stable read no violation", 1'b0, atomic_vio_o);
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== testbench/csr_unit_assertions.sv ====
`timescale 1ns/1ps

module csr_unit_assertions (
  input logic               clk,
  input logic               reset,
  input csr_pkg::csr_data_t frm_i,
  input csr_pkg::csr_data_t status_i,
  input logic               atomic_vio_i
);

  // frm only keeps the low word
  frm_upper_zero: assert property (@(posedge clk) disable iff (reset)
    frm_i[63:32] == 32'h0)
    else $error("frm_o upper word is not zero");

  // no status bit outside the writable set can ever appear
  status_in_mask: assert property (@(posedge clk) disable iff (reset)
    (status_i & ~csr_pkg::STATUS_WRITE_MASK) == '0)
    else $error("status_o has bits outside the write mask");

  // checkpoint starts out invalid
  no_vio_after_reset: assert property (@(posedge clk) $fell(reset) |-> !atomic_vio_i)
    else $error("atomic_vio_o high right after reset release");

endmodule

bind csr_unit csr_unit_assertions u_assertions (
  .clk          (clk),
  .reset        (reset),
  .frm_i        (frm_o),
  .status_i     (status_o),
  .atomic_vio_i (atomic_vio_o)
);

// ==== csr/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit #(
  parameter int COMMIT_WIDTH = 4
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          flush_i,
  // staged write from the CSR instruction
  input  logic                          wr_en_i,
  input  csr_pkg::csr_wr_req_t          wr_req_i,
  input  logic                          commit_i,
  // read port
  input  logic                          rd_en_i,
  input  csr_pkg::csr_addr_t            rd_addr_i,
  output csr_pkg::csr_data_t            rd_data_o,
  output logic                          atomic_vio_o,
  // commit-stage events
  input  logic [$clog2(COMMIT_WIDTH):0] retired_i,
  input  trap_pkg::exc_report_t         exc_i,
  input  logic                          sret_i,
  input  csr_pkg::csr_data_t            fflags_i,
  // status copies for the front end and FPU
  output csr_pkg::csr_data_t            epc_o,
  output csr_pkg::csr_data_t            evec_o,
  output csr_pkg::csr_data_t            status_o,
  output csr_pkg::csr_data_t            frm_o
);

  csr_pkg::csr_wr_strobe_t wr_strobe;
  csr_pkg::csr_data_t      wr_data;
  csr_pkg::csr_set_t       csrs;

  // holds the write until commit, then decodes it to a strobe
  csr_write_stage u_write_stage (
    .clk       (clk),
    .reset     (reset),
    .flush_i   (flush_i),
    .wr_en_i   (wr_en_i),
    .wr_req_i  (wr_req_i),
    .commit_i  (commit_i),
    .strobe_o  (wr_strobe),
    .wr_data_o (wr_data)
  );

  // architectural registers
  csr_reg_bank #(
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) u_reg_bank (
    .clk       (clk),
    .reset     (reset),
    .strobe_i  (wr_strobe),
    .wr_data_i (wr_data),
    .retired_i (retired_i),
    .exc_i     (exc_i),
    .sret_i    (sret_i),
    .fflags_i  (fflags_i),
    .csrs_o    (csrs)
  );

  // read mux plus the atomicity checkpoint
  csr_read_port u_read_port (
    .clk          (clk),
    .reset        (reset),
    .flush_i      (flush_i),
    .commit_i     (commit_i),
    .rd_en_i      (rd_en_i),
    .rd_addr_i    (rd_addr_i),
    .csrs_i       (csrs),
    .rd_data_o    (rd_data_o),
    .atomic_vio_o (atomic_vio_o)
  );

  // live register copies
  assign epc_o    = csrs.epc;
  assign evec_o   = csrs.evec;
  assign status_o = csrs.status;
  assign frm_o    = csrs.frm;

endmodule

// ==== csr/csr_read_port.sv ====
`timescale 1ns/1ps

module csr_read_port (
  input  logic               clk,
  input  logic               reset,
  input  logic               flush_i,
  input  logic               commit_i,
  input  logic               rd_en_i,
  input  csr_pkg::csr_addr_t rd_addr_i,
  input  csr_pkg::csr_set_t  csrs_i,
  output csr_pkg::csr_data_t rd_data_o,
  output logic               atomic_vio_o
);

  csr_pkg::csr_addr_t chkpt_addr_q;
  csr_pkg::csr_data_t chkpt_data_q;
  logic               chkpt_valid_q;
  csr_pkg::csr_data_t chkpt_live;

  // address to live value, dropped and unmapped addresses give zero
  function automatic csr_pkg::csr_data_t select_csr(
    input csr_pkg::csr_addr_t addr,
    input csr_pkg::csr_set_t  csrs
  );
    csr_pkg::csr_data_t val;
    case (addr)
      csr_pkg::ADDR_FFLAGS:   val = csrs.fflags;
      csr_pkg::ADDR_FRM:      val = csrs.frm;
      csr_pkg::ADDR_FCSR:     val = csrs.fcsr;
      csr_pkg::ADDR_SUP0:     val = csrs.sup0;
      csr_pkg::ADDR_SUP1:     val = csrs.sup1;
      csr_pkg::ADDR_EPC:      val = csrs.epc;
      csr_pkg::ADDR_BADVADDR: val = csrs.badvaddr;
      csr_pkg::ADDR_COUNT:    val = csrs.count;
      csr_pkg::ADDR_EVEC:     val = csrs.evec;
      csr_pkg::ADDR_CAUSE:    val = csrs.cause;
      csr_pkg::ADDR_STATUS:   val = csrs.status;
      csr_pkg::ADDR_CYCLE:    val = csrs.cycle;
      csr_pkg::ADDR_TIME:     val = csrs.time_csr;
      csr_pkg::ADDR_INSTRET:  val = csrs.instret;
      default:                val = '0;
    endcase
    return val;
  endfunction

  // zero-latency read
  assign rd_data_o = select_csr(rd_addr_i, csrs_i);

  // remember what the CSR instruction saw
  always_ff @(posedge clk)
  begin
    if (rd_en_i)
    begin
      chkpt_addr_q <= rd_addr_i;
      chkpt_data_q <= rd_data_o;
    end
  end

  // checkpoint lives until the instruction commits or is flushed
  // a new read in the same cycle re-arms it
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      chkpt_valid_q <= 1'b0;
    end
    else if (rd_en_i)
    begin
      chkpt_valid_q <= 1'b1;
    end
    else if (flush_i || commit_i)
    begin
      chkpt_valid_q <= 1'b0;
    end
  end

  // unmapped addresses read zero both times, so they never mismatch
  assign chkpt_live = select_csr(chkpt_addr_q, csrs_i);

  // retire logic replays the CSR instruction on a violation
  assign atomic_vio_o = chkpt_valid_q && (chkpt_live != chkpt_data_q);

endmodule

// ==== csr/csr_reg_bank.sv ====
`timescale 1ns/1ps

module csr_reg_bank #(
  parameter int COMMIT_WIDTH = 4
) (
  input  logic                          clk,
  input  logic                          reset,
  // committed write
  input  csr_pkg::csr_wr_strobe_t       strobe_i,
  input  csr_pkg::csr_data_t            wr_data_i,
  // per-cycle commit events
  input  logic [$clog2(COMMIT_WIDTH):0] retired_i,
  input  trap_pkg::exc_report_t         exc_i,
  input  logic                          sret_i,
  input  csr_pkg::csr_data_t            fflags_i,
  output csr_pkg::csr_set_t             csrs_o
);

  csr_pkg::csr_set_t  csrs_q;

  csr_pkg::csr_data_t fflags_acc;
  csr_pkg::csr_data_t epc_next;
  csr_pkg::csr_data_t badvaddr_next;
  csr_pkg::csr_data_t count_next;
  csr_pkg::csr_data_t cause_next;
  csr_pkg::csr_data_t status_next;

  // accrued FP exception flags, low word only
  assign fflags_acc = fflags_i & csr_pkg::LOW_WORD_MASK;

  // retired instructions plus one for an excepting instruction
  assign count_next = csrs_q.count
                    + csr_pkg::csr_data_t'(retired_i)
                    + csr_pkg::csr_data_t'(exc_i.valid);

  // trap capture
  assign epc_next   = exc_i.valid ? csr_pkg::csr_data_t'(exc_i.pc) : csrs_q.epc;
  assign cause_next = exc_i.valid ? csr_pkg::csr_data_t'(exc_i.cause) : csrs_q.cause;

  // faulting address picked by cause
  always_comb
  begin
    badvaddr_next = csrs_q.badvaddr;
    if (exc_i.valid)
    begin
      case (exc_i.cause)
        trap_pkg::CAUSE_MISALIGNED_FETCH,
        trap_pkg::CAUSE_FAULT_FETCH:
          badvaddr_next = csr_pkg::csr_data_t'(exc_i.pc);
        trap_pkg::CAUSE_MISALIGNED_LOAD,
        trap_pkg::CAUSE_FAULT_LOAD:
          badvaddr_next = csr_pkg::csr_data_t'(exc_i.ld_addr);
        trap_pkg::CAUSE_MISALIGNED_STORE,
        trap_pkg::CAUSE_FAULT_STORE:
          badvaddr_next = csr_pkg::csr_data_t'(exc_i.st_addr);
        // other causes keep the old address
        default:
          badvaddr_next = csrs_q.badvaddr;
      endcase
    end
  end

  // sret pops the previous mode and interrupt enable
  always_comb
  begin
    status_next = csrs_q.status;
    if (sret_i)
    begin
      status_next[csr_pkg::SR_S]  = csrs_q.status[csr_pkg::SR_PS];
      status_next[csr_pkg::SR_EI] = csrs_q.status[csr_pkg::SR_PEI];
    end
  end

  // a committed write always wins over the autonomous update
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      csrs_q        <= '0;
      csrs_q.status <= csr_pkg::STATUS_RESET;
    end
    else
    begin
      // fflags and fcsr both soak up the retiring FP flags
      csrs_q.fflags <= strobe_i.fflags ? (wr_data_i & csr_pkg::LOW_WORD_MASK)
                                       : (csrs_q.fflags | fflags_acc);
      csrs_q.frm    <= strobe_i.frm ? (wr_data_i & csr_pkg::LOW_WORD_MASK)
                                    : csrs_q.frm;
      csrs_q.fcsr   <= strobe_i.fcsr ? wr_data_i : (csrs_q.fcsr | fflags_acc);

      // scratch and vector, software only
      csrs_q.sup0   <= strobe_i.sup0 ? wr_data_i : csrs_q.sup0;
      csrs_q.sup1   <= strobe_i.sup1 ? wr_data_i : csrs_q.sup1;
      csrs_q.evec   <= strobe_i.evec ? wr_data_i : csrs_q.evec;

      csrs_q.epc      <= strobe_i.epc ? wr_data_i : epc_next;
      csrs_q.badvaddr <= strobe_i.badvaddr ? wr_data_i : badvaddr_next;
      csrs_q.cause    <= strobe_i.cause ? wr_data_i : cause_next;
      csrs_q.status   <= strobe_i.status ? (wr_data_i & csr_pkg::STATUS_WRITE_MASK)
                                         : status_next;

      // user counters shadow count's next value
      csrs_q.count    <= strobe_i.count ? wr_data_i : count_next;
      csrs_q.cycle    <= strobe_i.cycle ? wr_data_i : count_next;
      csrs_q.time_csr <= strobe_i.time_csr ? wr_data_i : count_next;
      csrs_q.instret  <= strobe_i.instret ? wr_data_i : count_next;
    end
  end

  assign csrs_o = csrs_q;

endmodule

// ==== csr/csr_write_stage.sv ====
`timescale 1ns/1ps

module csr_write_stage (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    flush_i,
  input  logic                    wr_en_i,
  input  csr_pkg::csr_wr_req_t    wr_req_i,
  input  logic                    commit_i,
  output csr_pkg::csr_wr_strobe_t strobe_o,
  output csr_pkg::csr_data_t      wr_data_o
);

  csr_pkg::csr_wr_req_t staged_q;
  logic                 pending_q;

  // staged address and data, only meaningful while pending
  always_ff @(posedge clk)
  begin
    if (wr_en_i)
    begin
      staged_q <= wr_req_i;
    end
  end

  // a new write beats a flush in the same cycle
  // commit leaves the flag set, only one CSR op is ever in flight
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pending_q <= 1'b0;
    end
    else if (wr_en_i)
    begin
      pending_q <= 1'b1;
    end
    else if (flush_i)
    begin
      pending_q <= 1'b0;
    end
  end

  // commit-time decode, unmapped addresses give no strobe
  always_comb
  begin
    strobe_o = '0;
    if (commit_i && pending_q)
    begin
      case (staged_q.addr)
        csr_pkg::ADDR_FFLAGS:   strobe_o.fflags   = 1'b1;
        csr_pkg::ADDR_FRM:      strobe_o.frm      = 1'b1;
        csr_pkg::ADDR_FCSR:     strobe_o.fcsr     = 1'b1;
        csr_pkg::ADDR_SUP0:     strobe_o.sup0     = 1'b1;
        csr_pkg::ADDR_SUP1:     strobe_o.sup1     = 1'b1;
        csr_pkg::ADDR_EPC:      strobe_o.epc      = 1'b1;
        csr_pkg::ADDR_BADVADDR: strobe_o.badvaddr = 1'b1;
        csr_pkg::ADDR_COUNT:    strobe_o.count    = 1'b1;
        csr_pkg::ADDR_EVEC:     strobe_o.evec     = 1'b1;
        csr_pkg::ADDR_CAUSE:    strobe_o.cause    = 1'b1;
        csr_pkg::ADDR_STATUS:   strobe_o.status   = 1'b1;
        csr_pkg::ADDR_CYCLE:    strobe_o.cycle    = 1'b1;
        csr_pkg::ADDR_TIME:     strobe_o.time_csr = 1'b1;
        csr_pkg::ADDR_INSTRET:  strobe_o.instret  = 1'b1;
        default:                strobe_o          = '0;
      endcase
    end
  end

  assign wr_data_o = staged_q.data;

endmodule

// ==== common/trap_pkg.sv ====
package trap_pkg;

  localparam int CAUSE_WIDTH = 4;
  // pc and virtual addresses are full 64-bit values
  localparam int VADDR_WIDTH = 64;

  typedef logic [CAUSE_WIDTH-1:0] cause_t;

  // exception causes that carry a faulting address
  localparam cause_t CAUSE_MISALIGNED_FETCH = 4'd0;
  localparam cause_t CAUSE_FAULT_FETCH      = 4'd1;
  localparam cause_t CAUSE_MISALIGNED_LOAD  = 4'd4;
  localparam cause_t CAUSE_MISALIGNED_STORE = 4'd5;
  localparam cause_t CAUSE_FAULT_LOAD       = 4'd6;
  localparam cause_t CAUSE_FAULT_STORE      = 4'd7;

  // exception reported by the commit stage
  typedef struct packed {
    logic                   valid;
    logic [VADDR_WIDTH-1:0] pc;
    cause_t                 cause;
    // addresses of the committing load and store
    logic [VADDR_WIDTH-1:0] ld_addr;
    logic [VADDR_WIDTH-1:0] st_addr;
  } exc_report_t;

endpackage

// ==== common/csr_pkg.sv ====
package csr_pkg;

  // register and address widths
  localparam int CSR_WIDTH      = 64;
  localparam int CSR_ADDR_WIDTH = 12;

  typedef logic [CSR_WIDTH-1:0]      csr_data_t;
  typedef logic [CSR_ADDR_WIDTH-1:0] csr_addr_t;

  // floating-point CSRs
  localparam csr_addr_t ADDR_FFLAGS   = 12'h001;
  localparam csr_addr_t ADDR_FRM      = 12'h002;
  localparam csr_addr_t ADDR_FCSR     = 12'h003;
  // supervisor CSRs, holes at 504, 505 and 507
  localparam csr_addr_t ADDR_SUP0     = 12'h500;
  localparam csr_addr_t ADDR_SUP1     = 12'h501;
  localparam csr_addr_t ADDR_EPC      = 12'h502;
  localparam csr_addr_t ADDR_BADVADDR = 12'h503;
  localparam csr_addr_t ADDR_COUNT    = 12'h506;
  localparam csr_addr_t ADDR_EVEC     = 12'h508;
  localparam csr_addr_t ADDR_CAUSE    = 12'h509;
  localparam csr_addr_t ADDR_STATUS   = 12'h50a;
  // user counters, low halves only
  localparam csr_addr_t ADDR_CYCLE    = 12'hc00;
  localparam csr_addr_t ADDR_TIME     = 12'hc01;
  localparam csr_addr_t ADDR_INSTRET  = 12'hc02;

  // status bit positions
  localparam int SR_S   = 0;
  localparam int SR_PS  = 1;
  localparam int SR_EI  = 2;
  localparam int SR_PEI = 3;
  localparam int SR_EF  = 4;
  localparam int SR_U64 = 5;
  localparam int SR_S64 = 6;
  localparam int SR_VM  = 7;

  // out of reset in supervisor mode with 64-bit user and supervisor
  localparam csr_data_t STATUS_RESET = (csr_data_t'(1) << SR_S)
                                     | (csr_data_t'(1) << SR_U64)
                                     | (csr_data_t'(1) << SR_S64);

  // software-writable status bits, EA and the interrupt fields excluded
  localparam csr_data_t STATUS_WRITE_MASK = (csr_data_t'(1) << SR_S)
                                          | (csr_data_t'(1) << SR_PS)
                                          | (csr_data_t'(1) << SR_EI)
                                          | (csr_data_t'(1) << SR_PEI)
                                          | (csr_data_t'(1) << SR_EF)
                                          | (csr_data_t'(1) << SR_U64)
                                          | (csr_data_t'(1) << SR_S64)
                                          | (csr_data_t'(1) << SR_VM);

  // fflags and frm keep only the low word
  localparam csr_data_t LOW_WORD_MASK = 64'h0000_0000_ffff_ffff;

  // write held until the CSR instruction commits
  typedef struct packed {
    csr_addr_t addr;
    csr_data_t data;
  } csr_wr_req_t;

  // one strobe per kept register
  typedef struct packed {
    logic fflags;
    logic frm;
    logic fcsr;
    logic sup0;
    logic sup1;
    logic epc;
    logic badvaddr;
    logic count;
    logic evec;
    logic cause;
    logic status;
    logic cycle;
    logic time_csr;
    logic instret;
  } csr_wr_strobe_t;

  // full register set, same field order as the strobes
  typedef struct packed {
    csr_data_t fflags;
    csr_data_t frm;
    csr_data_t fcsr;
    csr_data_t sup0;
    csr_data_t sup1;
    csr_data_t epc;
    csr_data_t badvaddr;
    csr_data_t count;
    csr_data_t evec;
    csr_data_t cause;
    csr_data_t status;
    csr_data_t cycle;
    csr_data_t time_csr;
    csr_data_t instret;
  } csr_set_t;

endpackage
